// File: logic/vec_isa_pkg.sv
// -----------------------------------------------
// Instruction-level types of the vector unit
// Operations, register index, vector length,
// element width code and scalar operand
// -----------------------------------------------
package vec_isa_pkg;

  // Supported vector operations
  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VMAND,
    VMV,
    VLE,
    VSE
  } vop_e;

  // Architectural vector registers
  localparam int unsigned NR_VREGS = 32;
  typedef logic [4:0] vreg_t;

  // v0 holds the mask
  localparam vreg_t VMASK = 5'd0;

  // Vector length in elements
  typedef logic [3:0] vlen_t;

  // Element width, bytes = 1 << code
  typedef logic [1:0] eew_t;

  // Scalar operand or memory address
  typedef logic [31:0] elen_t;

endpackage

// File: logic/vec_arch_pkg.sv
// -----------------------------------------------
// Micro-architecture constants of the vector unit
// Element counts, instruction ids, unit encoding
// -----------------------------------------------
package vec_arch_pkg;

  // Lanes plus load, store and mask units
  localparam int unsigned NR_LANES = 2;
  localparam int unsigned NR_PES   = NR_LANES + 3;

  // Instructions in flight
  localparam int unsigned NR_VINSN = 8;
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;

  // One bit per instruction id
  typedef logic [NR_VINSN-1:0] vinsn_mask_t;

  // Functional unit that executes an instruction
  typedef enum logic [1:0] {
    LANES,
    LOAD,
    STORE,
    MASK
  } vfu_e;

  // Element index of each unit, counted after the lanes
  localparam int unsigned OFFSET_LOAD  = 0;
  localparam int unsigned OFFSET_STORE = 1;
  localparam int unsigned OFFSET_MASK  = 2;

endpackage

// File: logic/vec_sequencer.sv
// -----------------------------------------------
// Vector instruction sequencer
// Id allocation, register access lists, hazard
// masks, request broadcast, memory response wait
// -----------------------------------------------
module vec_sequencer (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // Dispatcher side
  input  logic                                                 req_valid_i,
  input  vec_isa_pkg::vop_e                                    req_op_i,
  input  vec_isa_pkg::vreg_t                                   req_vd_i,
  input  vec_isa_pkg::vreg_t                                   req_vs1_i,
  input  vec_isa_pkg::vreg_t                                   req_vs2_i,
  input  logic                                                 req_use_vd_i,
  input  logic                                                 req_use_vs1_i,
  input  logic                                                 req_use_vs2_i,
  input  logic                                                 req_vm_i,
  input  vec_isa_pkg::vlen_t                                   req_vl_i,
  input  vec_isa_pkg::eew_t                                    req_eew_i,
  input  vec_isa_pkg::elen_t                                   req_scalar_i,
  output logic                                                 req_ready_o,
  output logic                                                 resp_valid_o,
  output logic                                                 resp_error_o,
  output logic                                                 idle_o,
  // Broadcast to the processing elements
  output logic                                                 pe_req_valid_o,
  output vec_arch_pkg::vid_t                                   pe_req_id_o,
  output vec_isa_pkg::vop_e                                    pe_req_op_o,
  output vec_arch_pkg::vfu_e                                   pe_req_vfu_o,
  output logic                                                 pe_req_vm_o,
  output vec_isa_pkg::vlen_t                                   pe_req_vl_o,
  output vec_isa_pkg::eew_t                                    pe_req_eew_o,
  output vec_isa_pkg::elen_t                                   pe_req_scalar_o,
  output vec_arch_pkg::vinsn_mask_t                            hazard_vs1_o,
  output vec_arch_pkg::vinsn_mask_t                            hazard_vs2_o,
  output vec_arch_pkg::vinsn_mask_t                            hazard_vd_o,
  output vec_arch_pkg::vinsn_mask_t                            hazard_vm_o,
  output vec_arch_pkg::vinsn_mask_t                            vinsn_running_o,
  input  logic [vec_arch_pkg::NR_PES-1:0]                      pe_ready_i,
  input  vec_arch_pkg::vinsn_mask_t [vec_arch_pkg::NR_PES-1:0] pe_done_i,
  // Address generator
  input  logic                                                 addrgen_ack_i,
  input  logic                                                 addrgen_error_i
);

  // WAIT holds the dispatcher until the address generator answers
  typedef enum logic {IDLE, WAIT} state_e;
  state_e state_d, state_q;

  // Running ids per element and over all elements
  vec_arch_pkg::vinsn_mask_t [vec_arch_pkg::NR_PES-1:0] pe_running_d, pe_running_q;
  vec_arch_pkg::vinsn_mask_t                            vinsn_running_d, vinsn_running_q;

  vec_arch_pkg::vid_t next_id;
  logic               vinsn_full;

  // Last reader and last writer of each vector register
  vec_arch_pkg::vid_t [vec_isa_pkg::NR_VREGS-1:0] read_vid_d, read_vid_q;
  vec_arch_pkg::vid_t [vec_isa_pkg::NR_VREGS-1:0] write_vid_d, write_vid_q;
  logic [vec_isa_pkg::NR_VREGS-1:0]               read_valid_p, read_valid_d, read_valid_q;
  logic [vec_isa_pkg::NR_VREGS-1:0]               write_valid_p, write_valid_d, write_valid_q;

  vec_arch_pkg::vinsn_mask_t haz_vs1, haz_vs2, haz_vd, haz_vm;
  vec_arch_pkg::vfu_e        req_vfu;
  logic                      no_operand;
  logic                      any_hazard;
  logic                      accept;

  // Unit that executes an operation
  function automatic vec_arch_pkg::vfu_e vfu_of(vec_isa_pkg::vop_e op);
    vec_arch_pkg::vfu_e vfu;
    case (op)
      vec_isa_pkg::VMAND: vfu = vec_arch_pkg::MASK;
      vec_isa_pkg::VLE:   vfu = vec_arch_pkg::LOAD;
      vec_isa_pkg::VSE:   vfu = vec_arch_pkg::STORE;
      default:            vfu = vec_arch_pkg::LANES;
    endcase
    return vfu;
  endfunction

  // Lowest free id wins
  always_comb begin
    next_id = '0;
    for (int i = vec_arch_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!vinsn_running_q[i])
        next_id = vec_arch_pkg::vid_t'(i);
    end
  end
  assign vinsn_full = &vinsn_running_q;

  // Entries of finished ids no longer count
  always_comb begin
    for (int v = 0; v < vec_isa_pkg::NR_VREGS; v++) begin
      read_valid_p[v]  = read_valid_q[v] & vinsn_running_q[read_vid_q[v]];
      write_valid_p[v] = write_valid_q[v] & vinsn_running_q[write_vid_q[v]];
    end
  end

  // Hazard masks of the incoming request
  always_comb begin
    haz_vs1 = '0;
    haz_vs2 = '0;
    haz_vd  = '0;
    haz_vm  = '0;
    // RAW on the sources and the mask register
    if (req_use_vs1_i && write_valid_p[req_vs1_i])
      haz_vs1[write_vid_q[req_vs1_i]] = 1'b1;
    if (req_use_vs2_i && write_valid_p[req_vs2_i])
      haz_vs2[write_vid_q[req_vs2_i]] = 1'b1;
    if (!req_vm_i && write_valid_p[vec_isa_pkg::VMASK])
      haz_vm[write_vid_q[vec_isa_pkg::VMASK]] = 1'b1;
    // WAR when an older instruction still reads vd
    if (req_use_vd_i && read_valid_p[req_vd_i]) begin
      haz_vs1[read_vid_q[req_vd_i]] = 1'b1;
      haz_vs2[read_vid_q[req_vd_i]] = 1'b1;
      haz_vm[read_vid_q[req_vd_i]]  = 1'b1;
    end
    // WAW
    if (req_use_vd_i && write_valid_p[req_vd_i])
      haz_vd[write_vid_q[req_vd_i]] = 1'b1;
  end

  assign req_vfu    = vfu_of(req_op_i);
  assign no_operand = !req_use_vs1_i && !req_use_vs2_i && req_vm_i;
  assign any_hazard = |{haz_vs1, haz_vs2, haz_vd, haz_vm};

  // All elements free, an id left, no broadcast in flight
  // Operand-less instructions also wait out their hazards
  assign req_ready_o = (state_q == IDLE) && (&pe_ready_i) && !vinsn_full &&
                       !pe_req_valid_o && !(no_operand && any_hazard);
  assign accept      = req_valid_i && req_ready_o;

  // Memory response straight from the ack
  assign resp_valid_o = (state_q == WAIT) && addrgen_ack_i;
  assign resp_error_o = resp_valid_o && addrgen_error_i;

  always_comb begin
    state_d       = state_q;
    pe_running_d  = pe_running_q;
    read_vid_d    = read_vid_q;
    write_vid_d   = write_vid_q;
    read_valid_d  = read_valid_p;
    write_valid_d = write_valid_p;
    // Retire finished ids per element
    for (int pe = 0; pe < vec_arch_pkg::NR_PES; pe++)
      pe_running_d[pe] &= ~pe_done_i[pe];
    if (state_q == WAIT && addrgen_ack_i)
      state_d = IDLE;
    if (accept) begin
      // Mark target elements
      case (req_vfu)
        vec_arch_pkg::LOAD:
          pe_running_d[vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_LOAD][next_id] = 1'b1;
        vec_arch_pkg::STORE:
          pe_running_d[vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_STORE][next_id] = 1'b1;
        vec_arch_pkg::MASK:
          pe_running_d[vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_MASK][next_id] = 1'b1;
        default:
          for (int l = 0; l < vec_arch_pkg::NR_LANES; l++)
            pe_running_d[l][next_id] = 1'b1;
      endcase
      // Masked work also runs on the mask unit
      if (!req_vm_i)
        pe_running_d[vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_MASK][next_id] = 1'b1;
      if (req_vfu == vec_arch_pkg::LOAD || req_vfu == vec_arch_pkg::STORE)
        state_d = WAIT;
      // Record new accesses
      if (req_use_vd_i) begin
        write_vid_d[req_vd_i]   = next_id;
        write_valid_d[req_vd_i] = 1'b1;
      end
      if (req_use_vs1_i) begin
        read_vid_d[req_vs1_i]   = next_id;
        read_valid_d[req_vs1_i] = 1'b1;
      end
      if (req_use_vs2_i) begin
        read_vid_d[req_vs2_i]   = next_id;
        read_valid_d[req_vs2_i] = 1'b1;
      end
      if (!req_vm_i) begin
        read_vid_d[vec_isa_pkg::VMASK]   = next_id;
        read_valid_d[vec_isa_pkg::VMASK] = 1'b1;
      end
    end
  end

  always_comb begin
    vinsn_running_d = '0;
    for (int pe = 0; pe < vec_arch_pkg::NR_PES; pe++)
      vinsn_running_d |= pe_running_d[pe];
  end

  assign vinsn_running_o = vinsn_running_q;
  assign idle_o          = ~|vinsn_running_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= IDLE;
      pe_running_q    <= '0;
      vinsn_running_q <= '0;
      read_valid_q    <= '0;
      write_valid_q   <= '0;
      pe_req_valid_o  <= 1'b0;
    end else begin
      state_q         <= state_d;
      pe_running_q    <= pe_running_d;
      vinsn_running_q <= vinsn_running_d;
      read_valid_q    <= read_valid_d;
      write_valid_q   <= write_valid_d;
      pe_req_valid_o  <= accept;
    end
  end

  // Id lists and broadcast payload
  always_ff @(posedge clk_i) begin
    read_vid_q  <= read_vid_d;
    write_vid_q <= write_vid_d;
    if (accept) begin
      pe_req_id_o     <= next_id;
      pe_req_op_o     <= req_op_i;
      pe_req_vfu_o    <= req_vfu;
      pe_req_vm_o     <= req_vm_i;
      pe_req_vl_o     <= req_vl_i;
      pe_req_eew_o    <= req_eew_i;
      pe_req_scalar_o <= req_scalar_i;
      hazard_vs1_o    <= haz_vs1;
      hazard_vs2_o    <= haz_vs2;
      hazard_vd_o     <= haz_vd;
      hazard_vm_o     <= haz_vm;
    end
  end

  // Granted id was not in use
  a_accept_free_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> !vinsn_running_q[next_id]);

  // Broadcast lasts exactly one cycle
  a_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o |=> !pe_req_valid_o);

  // Every address generator ack lands in a WAIT
  a_resp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    addrgen_ack_i |-> state_q == WAIT);

endmodule

// File: logic/vec_pe.sv
// -----------------------------------------------
// Processing element: captures one request, waits
// on its hazards, runs vl cycles and pulses done
// -----------------------------------------------
module vec_pe #(
  parameter vec_arch_pkg::vfu_e PE_VFU  = vec_arch_pkg::LANES,
  parameter bit                 PE_MASK = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      pe_req_valid_i,
  input  vec_arch_pkg::vid_t        pe_req_id_i,
  input  vec_arch_pkg::vfu_e        pe_req_vfu_i,
  input  logic                      pe_req_vm_i,
  input  vec_isa_pkg::vlen_t        pe_req_vl_i,
  input  vec_arch_pkg::vinsn_mask_t hazard_vs1_i,
  input  vec_arch_pkg::vinsn_mask_t hazard_vs2_i,
  input  vec_arch_pkg::vinsn_mask_t hazard_vd_i,
  input  vec_arch_pkg::vinsn_mask_t hazard_vm_i,
  input  vec_arch_pkg::vinsn_mask_t vinsn_running_i,
  output logic                      ready_o,
  output vec_arch_pkg::vinsn_mask_t done_o
);

  typedef enum logic [1:0] {PE_IDLE, PE_WAIT, PE_RUN} pe_state_e;
  pe_state_e state_d, state_q;

  vec_arch_pkg::vid_t        id_q;
  vec_arch_pkg::vinsn_mask_t haz_q;
  vec_isa_pkg::vlen_t        cnt_q;
  logic                      capture;
  logic                      haz_clear;
  logic                      last;

  // Own unit, or any masked request on the mask element
  assign capture   = pe_req_valid_i && (pe_req_vfu_i == PE_VFU || (PE_MASK && !pe_req_vm_i));
  assign haz_clear = ~|(haz_q & vinsn_running_i);
  assign last      = cnt_q <= vec_isa_pkg::vlen_t'(1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      PE_IDLE: if (capture) state_d = PE_WAIT;
      PE_WAIT: if (haz_clear) state_d = PE_RUN;
      PE_RUN:  if (last) state_d = PE_IDLE;
      default: state_d = PE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      state_q <= PE_IDLE;
    else
      state_q <= state_d;
  end

  // Request payload and cycle counter
  always_ff @(posedge clk_i) begin
    if (capture) begin
      id_q  <= pe_req_id_i;
      haz_q <= hazard_vs1_i | hazard_vs2_i | hazard_vd_i | hazard_vm_i;
      cnt_q <= pe_req_vl_i;
    end else if (state_q == PE_RUN) begin
      cnt_q <= cnt_q - vec_isa_pkg::vlen_t'(1);
    end
  end

  assign ready_o = (state_q == PE_IDLE);

  always_comb begin
    done_o = '0;
    if (state_q == PE_RUN && last)
      done_o[id_q] = 1'b1;
  end

  // Sequencer only broadcasts to free elements
  a_no_capture_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    capture |-> state_q == PE_IDLE);

endmodule

// File: logic/vec_addrgen.sv
// -----------------------------------------------
// Address generator stub, acknowledges a memory
// instruction after 3 cycles with a misalign flag
// -----------------------------------------------
module vec_addrgen (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               pe_req_valid_i,
  input  vec_arch_pkg::vfu_e pe_req_vfu_i,
  input  vec_isa_pkg::elen_t scalar_i,
  input  vec_isa_pkg::eew_t  eew_i,
  output logic               ack_o,
  output logic               error_o
);

  logic                     mem_req;
  logic                     misaligned;
  logic [2:0]               vld_q;
  logic [2:0]               err_q;
  vec_isa_pkg::elen_t       align_mask;

  assign mem_req = pe_req_valid_i &&
                   (pe_req_vfu_i == vec_arch_pkg::LOAD || pe_req_vfu_i == vec_arch_pkg::STORE);

  // Low address bits must be zero for the element size
  assign align_mask = (vec_isa_pkg::elen_t'(1) << eew_i) - vec_isa_pkg::elen_t'(1);
  assign misaligned = |(scalar_i & align_mask);

  // Delay line, valid bits under reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)
      vld_q <= '0;
    else
      vld_q <= {vld_q[1:0], mem_req};
  end

  always_ff @(posedge clk_i) begin
    err_q <= {err_q[1:0], misaligned};
  end

  assign ack_o   = vld_q[2];
  assign error_o = err_q[2];

  // Sequencer waits for the ack before the next memory request
  a_one_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req |-> ~|vld_q);

endmodule

// File: logic/vec_core_top.sv
// -----------------------------------------------
// Vector issue subsystem top level
// Sequencer, processing elements, address generator
// -----------------------------------------------
module vec_core_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  input  vec_isa_pkg::vop_e         req_op_i,
  input  vec_isa_pkg::vreg_t        req_vd_i,
  input  vec_isa_pkg::vreg_t        req_vs1_i,
  input  vec_isa_pkg::vreg_t        req_vs2_i,
  input  logic                      req_use_vd_i,
  input  logic                      req_use_vs1_i,
  input  logic                      req_use_vs2_i,
  input  logic                      req_vm_i,
  input  vec_isa_pkg::vlen_t        req_vl_i,
  input  vec_isa_pkg::eew_t         req_eew_i,
  input  vec_isa_pkg::elen_t        req_scalar_i,
  output logic                      req_ready_o,
  output logic                      resp_valid_o,
  output logic                      resp_error_o,
  output logic                      idle_o,
  output logic                      issue_valid_o,
  output vec_arch_pkg::vid_t        issue_id_o,
  output vec_arch_pkg::vinsn_mask_t done_mask_o
);

  // Broadcast bus
  logic                      pe_req_valid;
  vec_arch_pkg::vid_t        pe_req_id;
  vec_arch_pkg::vfu_e        pe_req_vfu;
  logic                      pe_req_vm;
  vec_isa_pkg::vlen_t        pe_req_vl;
  vec_isa_pkg::eew_t         pe_req_eew;
  vec_isa_pkg::elen_t        pe_req_scalar;
  vec_arch_pkg::vinsn_mask_t hazard_vs1, hazard_vs2, hazard_vd, hazard_vm;
  vec_arch_pkg::vinsn_mask_t vinsn_running;

  // Element returns
  logic [vec_arch_pkg::NR_PES-1:0]                      pe_ready;
  vec_arch_pkg::vinsn_mask_t [vec_arch_pkg::NR_PES-1:0] pe_done;

  logic addrgen_ack;
  logic addrgen_error;

  vec_sequencer i_sequencer (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .req_vd_i        (req_vd_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_use_vd_i    (req_use_vd_i),
    .req_use_vs1_i   (req_use_vs1_i),
    .req_use_vs2_i   (req_use_vs2_i),
    .req_vm_i        (req_vm_i),
    .req_vl_i        (req_vl_i),
    .req_eew_i       (req_eew_i),
    .req_scalar_i    (req_scalar_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_error_o    (resp_error_o),
    .idle_o          (idle_o),
    .pe_req_valid_o  (pe_req_valid),
    .pe_req_id_o     (pe_req_id),
    .pe_req_op_o     (),
    .pe_req_vfu_o    (pe_req_vfu),
    .pe_req_vm_o     (pe_req_vm),
    .pe_req_vl_o     (pe_req_vl),
    .pe_req_eew_o    (pe_req_eew),
    .pe_req_scalar_o (pe_req_scalar),
    .hazard_vs1_o    (hazard_vs1),
    .hazard_vs2_o    (hazard_vs2),
    .hazard_vd_o     (hazard_vd),
    .hazard_vm_o     (hazard_vm),
    .vinsn_running_o (vinsn_running),
    .pe_ready_i      (pe_ready),
    .pe_done_i       (pe_done),
    .addrgen_ack_i   (addrgen_ack),
    .addrgen_error_i (addrgen_error)
  );

  // Lanes first, then load, store and mask units
  for (genvar g = 0; g < vec_arch_pkg::NR_PES; g++) begin : gen_pe
    localparam vec_arch_pkg::vfu_e VFU =
      (g < vec_arch_pkg::NR_LANES) ? vec_arch_pkg::LANES :
      (g == vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_LOAD)  ? vec_arch_pkg::LOAD  :
      (g == vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_STORE) ? vec_arch_pkg::STORE :
      vec_arch_pkg::MASK;

    vec_pe #(
      .PE_VFU  (VFU),
      .PE_MASK (1'(g == vec_arch_pkg::NR_LANES + vec_arch_pkg::OFFSET_MASK))
    ) i_pe (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .pe_req_valid_i  (pe_req_valid),
      .pe_req_id_i     (pe_req_id),
      .pe_req_vfu_i    (pe_req_vfu),
      .pe_req_vm_i     (pe_req_vm),
      .pe_req_vl_i     (pe_req_vl),
      .hazard_vs1_i    (hazard_vs1),
      .hazard_vs2_i    (hazard_vs2),
      .hazard_vd_i     (hazard_vd),
      .hazard_vm_i     (hazard_vm),
      .vinsn_running_i (vinsn_running),
      .ready_o         (pe_ready[g]),
      .done_o          (pe_done[g])
    );
  end

  vec_addrgen i_addrgen (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_valid_i (pe_req_valid),
    .pe_req_vfu_i   (pe_req_vfu),
    .scalar_i       (pe_req_scalar),
    .eew_i          (pe_req_eew),
    .ack_o          (addrgen_ack),
    .error_o        (addrgen_error)
  );

  assign issue_valid_o = pe_req_valid;
  assign issue_id_o    = pe_req_id;

  // Done bits of all elements
  always_comb begin
    done_mask_o = '0;
    for (int pe = 0; pe < vec_arch_pkg::NR_PES; pe++)
      done_mask_o |= pe_done[pe];
  end

endmodule

// File: sim/tb_vec_core.sv
// --------------------------------------------------
// Testbench of the vector issue subsystem
// Random instruction stream, reference model of ids,
// responses and dependence order, per-test report
// --------------------------------------------------
module tb_vec_core;

  localparam int NUM_INSTR = 300;
  localparam int TIMEOUT   = 2000;
  localparam int NUM_TESTS = 6;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_valid_i;
  vec_isa_pkg::vop_e         req_op_i;
  vec_isa_pkg::vreg_t        req_vd_i;
  vec_isa_pkg::vreg_t        req_vs1_i;
  vec_isa_pkg::vreg_t        req_vs2_i;
  logic                      req_use_vd_i;
  logic                      req_use_vs1_i;
  logic                      req_use_vs2_i;
  logic                      req_vm_i;
  vec_isa_pkg::vlen_t        req_vl_i;
  vec_isa_pkg::eew_t         req_eew_i;
  vec_isa_pkg::elen_t        req_scalar_i;
  logic                      req_ready_o;
  logic                      resp_valid_o;
  logic                      resp_error_o;
  logic                      idle_o;
  logic                      issue_valid_o;
  vec_arch_pkg::vid_t        issue_id_o;
  vec_arch_pkg::vinsn_mask_t done_mask_o;

  // Run control and per-test counters
  integer seed;
  bit     timed_out;
  bit     monitor_on;
  int     cycle;
  int     checks [1:NUM_TESTS];
  int     errs [1:NUM_TESTS];
  string  test_name [1:NUM_TESTS];

  // Reference model, indexed by acceptance order
  int accepted;
  int accept_cycle [NUM_INSTR];
  int done_cycle [NUM_INSTR];
  int done_cnt [NUM_INSTR];
  bit complete [NUM_INSTR];
  bit exp_error [NUM_INSTR];
  int preds [NUM_INSTR][5];
  int npred [NUM_INSTR];
  int last_reader [32];
  int last_writer [32];
  int id_owner [vec_arch_pkg::NR_VINSN];
  int issue_q [$];
  int mem_pending;

  vec_core_top i_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_op_i      (req_op_i),
    .req_vd_i      (req_vd_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_use_vd_i  (req_use_vd_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_use_vs2_i (req_use_vs2_i),
    .req_vm_i      (req_vm_i),
    .req_vl_i      (req_vl_i),
    .req_eew_i     (req_eew_i),
    .req_scalar_i  (req_scalar_i),
    .req_ready_o   (req_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_error_o  (resp_error_o),
    .idle_o        (idle_o),
    .issue_valid_o (issue_valid_o),
    .issue_id_o    (issue_id_o),
    .done_mask_o   (done_mask_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic int rand_range(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic compare_value(input int t, input string name, input longint got,
                               input longint expected);
    checks[t]++;
    assert (got == expected) else begin
      $display("CHECK FAILED time=%0t signal=%s got=%0h expected=%0h",
               $time, name, got, expected);
      errs[t]++;
    end
  endtask

  task automatic expect_true(input int t, input bit cond, input string msg);
    checks[t]++;
    assert (cond) else begin
      $display("ERROR at time %0t: %s", $time, msg);
      errs[t]++;
    end
  endtask

  task automatic init_model();
    accepted    = 0;
    mem_pending = -1;
    cycle       = 0;
    for (int s = 0; s < NUM_INSTR; s++) begin
      done_cnt[s] = 0;
      complete[s] = 1'b0;
      npred[s]    = 0;
    end
    for (int r = 0; r < 32; r++) begin
      last_reader[r] = -1;
      last_writer[r] = -1;
    end
    for (int i = 0; i < vec_arch_pkg::NR_VINSN; i++)
      id_owner[i] = -1;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      checks[t] = 0;
      errs[t]   = 0;
    end
    test_name[1] = "reset state";
    test_name[2] = "memory responses";
    test_name[3] = "issue ids";
    test_name[4] = "dependence order";
    test_name[5] = "operand-less stall";
    test_name[6] = "drain and done count";
  endtask

  task automatic drive_idle();
    req_valid_i   = 1'b0;
    req_op_i      = vec_isa_pkg::VADD;
    req_vd_i      = '0;
    req_vs1_i     = '0;
    req_vs2_i     = '0;
    req_use_vd_i  = 1'b0;
    req_use_vs1_i = 1'b0;
    req_use_vs2_i = 1'b0;
    req_vm_i      = 1'b1;
    req_vl_i      = vec_isa_pkg::vlen_t'(1);
    req_eew_i     = '0;
    req_scalar_i  = '0;
  endtask

  // Registers 0 to 7 only, so hazards are frequent
  task automatic drive_instr();
    req_op_i     = vec_isa_pkg::vop_e'(rand_range(6));
    req_vd_i     = vec_isa_pkg::vreg_t'(rand_range(8));
    req_vs1_i    = vec_isa_pkg::vreg_t'(rand_range(8));
    req_vs2_i    = vec_isa_pkg::vreg_t'(rand_range(8));
    req_vl_i     = vec_isa_pkg::vlen_t'(1 + rand_range(8));
    req_eew_i    = vec_isa_pkg::eew_t'(rand_range(4));
    req_scalar_i = $random(seed);
    // Half of the addresses aligned for every width
    if (rand_range(2) == 0)
      req_scalar_i[2:0] = 3'b000;
    req_vm_i = (rand_range(3) != 0);
    case (req_op_i)
      vec_isa_pkg::VMV: begin
        req_use_vd_i  = 1'b1;
        req_use_vs1_i = 1'b0;
        req_use_vs2_i = 1'b0;
        req_vm_i      = 1'b1;
      end
      vec_isa_pkg::VLE: begin
        req_use_vd_i  = 1'b1;
        req_use_vs1_i = 1'b0;
        req_use_vs2_i = 1'b0;
      end
      // Store data comes from vs1
      vec_isa_pkg::VSE: begin
        req_use_vd_i  = 1'b0;
        req_use_vs1_i = 1'b1;
        req_use_vs2_i = 1'b0;
      end
      default: begin
        req_use_vd_i  = 1'b1;
        req_use_vs1_i = 1'b1;
        req_use_vs2_i = 1'b1;
      end
    endcase
    req_valid_i = 1'b1;
  endtask

  // Older access that is still running becomes a predecessor
  task automatic add_pred(input int s, input int p);
    if (p >= 0 && !complete[p]) begin
      preds[s][npred[s]] = p;
      npred[s]++;
    end
  endtask

  task automatic record_accept();
    int s;
    s = accepted;
    accepted++;
    accept_cycle[s] = cycle;
    npred[s] = 0;
    // RAW on sources and mask, then WAR and WAW on vd
    if (req_use_vs1_i)
      add_pred(s, last_writer[req_vs1_i]);
    if (req_use_vs2_i)
      add_pred(s, last_writer[req_vs2_i]);
    if (!req_vm_i)
      add_pred(s, last_writer[vec_isa_pkg::VMASK]);
    if (req_use_vd_i) begin
      add_pred(s, last_reader[req_vd_i]);
      add_pred(s, last_writer[req_vd_i]);
    end
    if (!req_use_vs1_i && !req_use_vs2_i && req_vm_i)
      expect_true(5, npred[s] == 0,
                  $sformatf("operand-less instruction %0d accepted with %0d predecessors running",
                            s, npred[s]));
    if (req_use_vd_i)
      last_writer[req_vd_i] = s;
    if (req_use_vs1_i)
      last_reader[req_vs1_i] = s;
    if (req_use_vs2_i)
      last_reader[req_vs2_i] = s;
    if (!req_vm_i)
      last_reader[vec_isa_pkg::VMASK] = s;
    issue_q.push_back(s);
    if (req_op_i == vec_isa_pkg::VLE || req_op_i == vec_isa_pkg::VSE) begin
      expect_true(2, mem_pending < 0, "memory request accepted while a response is outstanding");
      mem_pending  = s;
      // Address must be a multiple of the element bytes
      exp_error[s] = (req_scalar_i % (32'd1 << req_eew_i)) != 0;
    end
  endtask

  task automatic take_issue();
    int s;
    expect_true(3, issue_q.size() > 0, "issue pulse without an accepted request");
    if (issue_q.size() > 0) begin
      s = issue_q.pop_front();
      compare_value(3, "issue_valid_o cycle", cycle, accept_cycle[s] + 1);
      expect_true(3, id_owner[issue_id_o] < 0,
                  $sformatf("id %0d issued while instruction %0d still runs",
                            issue_id_o, id_owner[issue_id_o]));
      id_owner[issue_id_o] = s;
    end
  endtask

  task automatic take_response();
    if (mem_pending < 0) begin
      expect_true(2, 1'b0, "resp_valid_o without an outstanding load or store");
    end else begin
      // Ack three cycles after the broadcast
      compare_value(2, "resp_valid_o cycle", cycle, accept_cycle[mem_pending] + 4);
      compare_value(2, "resp_error_o", resp_error_o, exp_error[mem_pending]);
      mem_pending = -1;
    end
  endtask

  task automatic retire_id(input int b);
    int s;
    s = id_owner[b];
    expect_true(6, s >= 0, $sformatf("done bit for id %0d with no running instruction", b));
    if (s >= 0) begin
      for (int k = 0; k < npred[s]; k++)
        expect_true(4, complete[preds[s][k]] && done_cycle[preds[s][k]] < cycle,
                    $sformatf("instruction %0d done before its predecessor %0d",
                              s, preds[s][k]));
      done_cnt[s]++;
      complete[s]   = 1'b1;
      done_cycle[s] = cycle;
      id_owner[b]   = -1;
    end
  endtask

  // Outputs sampled mid-cycle, inputs change 10 after the rising edge
  always @(negedge clk_i) begin
    cycle++;
    if (monitor_on) begin
      for (int b = 0; b < vec_arch_pkg::NR_VINSN; b++)
        if (done_mask_o[b])
          retire_id(b);
      if (issue_valid_o)
        take_issue();
      // Dispatcher held until the response, ack cycle included
      if (mem_pending >= 0 && cycle > accept_cycle[mem_pending])
        expect_true(2, !req_ready_o, "req_ready_o high while a memory response is outstanding");
      if (resp_valid_o)
        take_response();
      if (req_valid_i && req_ready_o)
        record_accept();
    end
  end

  task automatic wait_accept(input int n);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!req_ready_o && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!req_ready_o) begin
      $display("ERROR at time %0t: request %0d not accepted within %0d cycles",
               $time, n, TIMEOUT);
      timed_out = 1'b1;
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!(idle_o && issue_q.size() == 0 && mem_pending < 0) && waited < TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!idle_o) begin
      $display("ERROR at time %0t: idle_o did not return high within %0d cycles",
               $time, TIMEOUT);
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input int t);
    if (errs[t] == 0)
      $display("test %0d %-22s PASS  %0d checks", t, test_name[t], checks[t]);
    else
      $display("test %0d %-22s FAIL  %0d of %0d checks wrong", t, test_name[t],
               errs[t], checks[t]);
  endtask

  initial begin
    int total_errs;
    int total_checks;
    int passed;
    seed       = 8456;
    timed_out  = 1'b0;
    monitor_on = 1'b0;
    init_model();
    rst_ni = 1'b0;
    drive_idle();
    repeat (8) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    @(negedge clk_i);
    compare_value(1, "idle_o", idle_o, 1);
    compare_value(1, "req_ready_o", req_ready_o, 1);
    compare_value(1, "resp_valid_o", resp_valid_o, 0);
    report_test(1);
    monitor_on = 1'b1;
    @(posedge clk_i);
    #10;

    for (int n = 0; n < NUM_INSTR && !timed_out; n++) begin
      // Occasional gaps in the stream
      if (rand_range(4) == 0) begin
        drive_idle();
        repeat (1 + rand_range(3)) begin
          @(posedge clk_i);
          #10;
        end
      end
      drive_instr();
      wait_accept(n);
    end
    drive_idle();

    if (!timed_out) begin
      wait_idle();
      expect_true(2, mem_pending < 0, "load or store left without a response");
      expect_true(3, issue_q.size() == 0, "accepted request left without an issue pulse");
      compare_value(6, "idle_o", idle_o, 1);
      for (int s = 0; s < accepted; s++)
        compare_value(6, $sformatf("done count of instruction %0d", s), done_cnt[s], 1);
    end
    for (int t = 2; t <= NUM_TESTS; t++)
      report_test(t);

    total_errs   = 0;
    total_checks = 0;
    passed       = 0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      total_errs   += errs[t];
      total_checks += checks[t];
      if (errs[t] == 0)
        passed++;
    end
    $display("Summary: %0d of %0d tests passed, %0d instructions, %0d checks, %0d errors",
             passed, NUM_TESTS, accepted, total_checks, total_errs);
    if (!timed_out && total_errs == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: files.f
logic/vec_isa_pkg.sv
logic/vec_arch_pkg.sv
logic/vec_sequencer.sv
logic/vec_pe.sv
logic/vec_addrgen.sv
logic/vec_core_top.sv
sim/tb_vec_core.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_vec_core
FILELIST := files.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
